// File: Makefile
# Verilator build and run for the RV32I core testbench
VERILATOR ?= verilator
TOP       ?= core_tb
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f

.PHONY: sim clean

# The simulation exits with a failing status when the testbench stops on $fatal
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/alu.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module alu (
    input  rv_pkg::alu_op_e  op,
    input  logic [`XLEN-1:0] a,           // rs1
    input  logic [`XLEN-1:0] b,           // rs2
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] result,
    output logic             take_branch
);

    logic [`XLEN-1:0]         opb;
    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     lt_s;
    logic                     lt_u;

    // R-type and branches compare registers while all others use the immediate
    assign opb   = (op <= rv_pkg::alu_and ||
                    (op >= rv_pkg::alu_beq && op <= rv_pkg::alu_bgeu)) ? b : imm;
    assign shamt = opb[$clog2(`XLEN)-1:0];
    assign lt_s  = $signed(a) < $signed(opb);
    assign lt_u  = a < opb;

    always_comb begin
        case (op) inside
            rv_pkg::alu_add, rv_pkg::alu_addi, rv_pkg::alu_jalr,
            [rv_pkg::alu_lb:rv_pkg::alu_sw]:    result = a + opb; // Also load/store address
            rv_pkg::alu_sub:                    result = a - opb;
            rv_pkg::alu_sll, rv_pkg::alu_slli:  result = a << shamt;
            rv_pkg::alu_slt, rv_pkg::alu_slti:  result = {{(`XLEN-1){1'b0}}, lt_s};
            rv_pkg::alu_sltu, rv_pkg::alu_sltiu: result = {{(`XLEN-1){1'b0}}, lt_u};
            rv_pkg::alu_xor, rv_pkg::alu_xori:  result = a ^ opb;
            rv_pkg::alu_srl, rv_pkg::alu_srli:  result = a >> shamt;
            rv_pkg::alu_sra, rv_pkg::alu_srai:  result = $signed(a) >>> shamt;
            rv_pkg::alu_or, rv_pkg::alu_ori:    result = a | opb;
            rv_pkg::alu_and, rv_pkg::alu_andi:  result = a & opb;
            rv_pkg::alu_lui:                    result = imm;
            rv_pkg::alu_auipc, rv_pkg::alu_jal,
            [rv_pkg::alu_beq:rv_pkg::alu_bgeu]: result = pc + imm; // PC relative target
            default:                            result = '0;
        endcase

        case (op)
            rv_pkg::alu_beq:  take_branch = (a == b);
            rv_pkg::alu_bne:  take_branch = (a != b);
            rv_pkg::alu_blt:  take_branch = lt_s;
            rv_pkg::alu_bge:  take_branch = !lt_s;
            rv_pkg::alu_bltu: take_branch = lt_u;
            rv_pkg::alu_bgeu: take_branch = !lt_u;
            default:          take_branch = 1'b0;
        endcase
    end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module control_unit (
    input  rv_pkg::instr_u                instruction,
    output logic                          read,       // Load request
    output logic                          write,      // Store request
    output logic [2:0]                    funct3,     // Size for memory handler
    output logic [$clog2(`REG_COUNT)-1:0] reg1,
    output logic [$clog2(`REG_COUNT)-1:0] reg2,
    output logic [$clog2(`REG_COUNT)-1:0] regd,
    output logic                          en_read_1,
    output logic                          en_read_2,
    output logic                          en_write,
    output rv_pkg::wb_src_e               wb_src,
    output logic [`XLEN-1:0]              immediate,  // Sign extended
    output rv_pkg::alu_op_e               alu_op,
    output logic                          jump        // JAL or JALR
);

    always_comb begin
        read      = 1'b0;
        write     = 1'b0;
        en_read_1 = 1'b0;
        en_read_2 = 1'b0;
        en_write  = 1'b0;
        wb_src    = rv_pkg::wb_none;
        immediate = '0;
        alu_op    = rv_pkg::alu_none;
        jump      = 1'b0;
        // Field positions are shared by every format that has them
        funct3    = instruction.r.funct3;
        reg1      = instruction.r.rs1;
        reg2      = instruction.r.rs2;
        regd      = instruction.r.rd;

        case (instruction.r.opcode)
            7'b0110011: begin // R-type
                en_read_1 = 1'b1;
                en_read_2 = 1'b1;
                en_write  = 1'b1;
                wb_src    = rv_pkg::wb_alu;
                case ({instruction.r.funct7, funct3})
                    {7'd0, 3'b000}:  alu_op = rv_pkg::alu_add;
                    {7'd32, 3'b000}: alu_op = rv_pkg::alu_sub;
                    {7'd0, 3'b001}:  alu_op = rv_pkg::alu_sll;
                    {7'd0, 3'b010}:  alu_op = rv_pkg::alu_slt;
                    {7'd0, 3'b011}:  alu_op = rv_pkg::alu_sltu;
                    {7'd0, 3'b100}:  alu_op = rv_pkg::alu_xor;
                    {7'd0, 3'b101}:  alu_op = rv_pkg::alu_srl;
                    {7'd32, 3'b101}: alu_op = rv_pkg::alu_sra;
                    {7'd0, 3'b110}:  alu_op = rv_pkg::alu_or;
                    {7'd0, 3'b111}:  alu_op = rv_pkg::alu_and;
                    default:         alu_op = rv_pkg::alu_none;
                endcase
            end
            7'b0010011: begin // I-type ALU
                en_read_1 = 1'b1;
                en_write  = 1'b1;
                wb_src    = rv_pkg::wb_alu;
                immediate = {{20{instruction.i.imm[11]}}, instruction.i.imm};
                case (funct3)
                    3'b000: alu_op = rv_pkg::alu_addi;
                    3'b010: alu_op = rv_pkg::alu_slti;
                    3'b011: alu_op = rv_pkg::alu_sltiu;
                    3'b100: alu_op = rv_pkg::alu_xori;
                    3'b110: alu_op = rv_pkg::alu_ori;
                    3'b111: alu_op = rv_pkg::alu_andi;
                    3'b001: if (instruction.r.funct7 == 7'd0) alu_op = rv_pkg::alu_slli;
                    default: begin
                        if (instruction.r.funct7 == 7'd0) alu_op = rv_pkg::alu_srli;
                        else if (instruction.r.funct7 == 7'd32) alu_op = rv_pkg::alu_srai;
                    end
                endcase
            end
            7'b0000011: begin // Loads
                read      = 1'b1;
                en_read_1 = 1'b1;
                en_write  = 1'b1;
                wb_src    = rv_pkg::wb_mem;
                immediate = {{20{instruction.i.imm[11]}}, instruction.i.imm};
                case (funct3)
                    3'b000:  alu_op = rv_pkg::alu_lb;
                    3'b001:  alu_op = rv_pkg::alu_lh;
                    3'b010:  alu_op = rv_pkg::alu_lw;
                    3'b100:  alu_op = rv_pkg::alu_lbu;
                    3'b101:  alu_op = rv_pkg::alu_lhu;
                    default: alu_op = rv_pkg::alu_none;
                endcase
            end
            7'b0100011: begin // Stores
                write     = 1'b1;
                en_read_1 = 1'b1;
                en_read_2 = 1'b1; // Store data
                immediate = {{20{instruction.s.imm_hi[6]}}, instruction.s.imm_hi,
                             instruction.s.imm_lo};
                case (funct3)
                    3'b000:  alu_op = rv_pkg::alu_sb;
                    3'b001:  alu_op = rv_pkg::alu_sh;
                    3'b010:  alu_op = rv_pkg::alu_sw;
                    default: alu_op = rv_pkg::alu_none;
                endcase
            end
            7'b1100011: begin // Branches
                en_read_1 = 1'b1;
                en_read_2 = 1'b1;
                immediate = {{19{instruction.b.imm12}}, instruction.b.imm12,
                             instruction.b.imm11, instruction.b.imm10_5,
                             instruction.b.imm4_1, 1'b0};
                case (funct3)
                    3'b000:  alu_op = rv_pkg::alu_beq;
                    3'b001:  alu_op = rv_pkg::alu_bne;
                    3'b100:  alu_op = rv_pkg::alu_blt;
                    3'b101:  alu_op = rv_pkg::alu_bge;
                    3'b110:  alu_op = rv_pkg::alu_bltu;
                    3'b111:  alu_op = rv_pkg::alu_bgeu;
                    default: alu_op = rv_pkg::alu_none;
                endcase
            end
            7'b0110111, 7'b0010111: begin // LUI, AUIPC
                en_write  = 1'b1;
                wb_src    = rv_pkg::wb_alu;
                immediate = {instruction.u.imm, 12'b0};
                alu_op    = instruction.r.opcode[5] ? rv_pkg::alu_lui : rv_pkg::alu_auipc;
            end
            7'b1101111: begin // JAL
                en_write  = 1'b1;
                wb_src    = rv_pkg::wb_link;
                immediate = {{11{instruction.j.imm20}}, instruction.j.imm20,
                             instruction.j.imm19_12, instruction.j.imm11,
                             instruction.j.imm10_1, 1'b0};
                alu_op    = rv_pkg::alu_jal;
                jump      = 1'b1;
            end
            7'b1100111: begin // JALR
                en_read_1 = 1'b1;
                en_write  = 1'b1;
                wb_src    = rv_pkg::wb_link;
                immediate = {{20{instruction.i.imm[11]}}, instruction.i.imm};
                alu_op    = rv_pkg::alu_jalr;
                jump      = 1'b1;
            end
            default: ;
        endcase

        if (alu_op == rv_pkg::alu_none) begin // Unknown encoding only advances the PC
            read     = 1'b0;
            write    = 1'b0;
            en_write = 1'b0;
            wb_src   = rv_pkg::wb_none;
        end
    end

endmodule

// File: logic/core_sequencer.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module core_sequencer (
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [31:0]      imem_rdata,
    output logic [31:0]      instruction,  // Held from fetch to writeback
    input  logic             read,
    input  logic             write,
    input  logic             en_write,
    input  logic             jump,
    input  logic [2:0]       funct3,
    input  rv_pkg::wb_src_e  wb_src,
    input  rv_pkg::alu_op_e  alu_op,
    input  logic [`XLEN-1:0] alu_result,
    input  logic             take_branch,
    input  logic [`XLEN-1:0] rs2_data,
    output logic             reg_we,
    output logic [`XLEN-1:0] reg_wdata,
    mem_bus_if.seq           bus
);

    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_EXEC  = 2'd1;
    localparam logic [1:0] S_MEM   = 2'd2;
    localparam logic [1:0] S_WB    = 2'd3;

    logic [1:0]       state;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] load_data;
    logic             is_branch;

    assign imem_addr = pc;
    assign pc_plus4  = pc + 4;
    assign is_branch = (alu_op >= rv_pkg::alu_beq) && (alu_op <= rv_pkg::alu_bgeu);

    // Fields come from the held instruction so they stay stable until done
    assign bus.rd     = (state == S_MEM) && read;
    assign bus.wr     = (state == S_MEM) && write;
    assign bus.funct3 = funct3;
    assign bus.addr   = alu_result;
    assign bus.wdata  = rs2_data;

    assign reg_we = (state == S_WB) && en_write;

    always_comb begin
        case (wb_src)
            rv_pkg::wb_mem:  reg_wdata = load_data;
            rv_pkg::wb_link: reg_wdata = pc_plus4;   // Return address
            default:         reg_wdata = alu_result;
        endcase

        if (jump && alu_op == rv_pkg::alu_jalr) next_pc = {alu_result[`XLEN-1:1], 1'b0};
        else if (jump || (is_branch && take_branch)) next_pc = alu_result;
        else next_pc = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_FETCH;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                S_FETCH: state <= S_EXEC;
                S_EXEC:  state <= (read || write) ? S_MEM : S_WB;
                S_MEM:   if (bus.done) state <= S_WB;
                default: begin
                    state <= S_FETCH;
                    pc    <= next_pc;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH) instruction <= imem_rdata;
        if (bus.done) load_data <= bus.rdata;
    end

endmodule

// File: logic/mem_bus_if.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

interface mem_bus_if;
    logic             rd;      // Load request
    logic             wr;      // Store request
    logic [2:0]       funct3;  // Access size and sign
    logic [`XLEN-1:0] addr;    // Byte address
    logic [`XLEN-1:0] wdata;   // Unshifted store data
    logic [`XLEN-1:0] rdata;   // Extended load data valid with done
    logic             done;    // One cycle at end of transfer

    modport seq (output rd, output wr, output funct3, output addr, output wdata,
                 input rdata, input done);

    modport hdl (input rd, input wr, input funct3, input addr, input wdata,
                 output rdata, output done);
endinterface

// File: logic/memory_handler.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module memory_handler (
    input  logic                clk,
    input  logic                rst_n,
    mem_bus_if.hdl              bus,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [`PADDR_W-1:0] paddr,
    output logic [31:0]         pwdata,
    output logic [3:0]          pstrb,
    input  logic [31:0]         prdata,
    input  logic                pready
);

    localparam logic ST_SETUP  = 1'b0;
    localparam logic ST_ACCESS = 1'b1;

    logic        state;
    logic [1:0]  offset;     // Byte within the word
    logic [31:0] lane_data;  // Addressed lanes moved to bit 0

    assign offset   = bus.addr[1:0];
    assign psel     = bus.rd || bus.wr;   // Request is held through both phases
    assign penable  = (state == ST_ACCESS);
    assign pwrite   = bus.wr;
    assign paddr    = {bus.addr[`PADDR_W-1:2], 2'b00};
    assign bus.done = (state == ST_ACCESS) && pready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_SETUP;
        end else if (state == ST_SETUP) begin
            if (psel) state <= ST_ACCESS;
        end else if (pready) begin
            state <= ST_SETUP;
        end
    end

    // Store lane placement
    always_comb begin
        case (bus.funct3[1:0])
            2'b00: begin
                pstrb  = 4'b0001 << offset;
                pwdata = bus.wdata << {offset, 3'b000};
            end
            2'b01: begin
                pstrb  = 4'b0011 << {offset[1], 1'b0};
                pwdata = bus.wdata << {offset[1], 4'b0000};
            end
            default: begin
                pstrb  = 4'b1111;
                pwdata = bus.wdata;
            end
        endcase
        if (!bus.wr) pstrb = 4'b0000; // No strobes on reads
    end

    // Load extraction and extension
    always_comb begin
        lane_data = prdata >> {offset, 3'b000};
        case (bus.funct3)
            3'b000:  bus.rdata = {{24{lane_data[7]}}, lane_data[7:0]};
            3'b001:  bus.rdata = {{16{lane_data[15]}}, lane_data[15:0]};
            3'b100:  bus.rdata = {24'b0, lane_data[7:0]};
            3'b101:  bus.rdata = {16'b0, lane_data[15:0]};
            default: bus.rdata = prdata;
        endcase
    end

endmodule

// File: logic/register_file.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [$clog2(`REG_COUNT)-1:0] raddr1,
    input  logic [$clog2(`REG_COUNT)-1:0] raddr2,
    input  logic [$clog2(`REG_COUNT)-1:0] waddr,
    input  logic                          we,
    input  logic [`XLEN-1:0]              wdata,
    output logic [`XLEN-1:0]              rdata1,
    output logic [`XLEN-1:0]              rdata2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (we && waddr != '0) begin // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: logic/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN      32            // Data word width
`define REG_COUNT 32            // General purpose registers
`define RESET_PC  32'h0000_0000 // First fetch address
`define PADDR_W   32            // APB address width

`endif

// File: logic/rv_core_top.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_top (
    input  logic                clk,
    input  logic                rst_n,
    output logic [`XLEN-1:0]    imem_addr,
    input  logic [31:0]         imem_rdata,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [`PADDR_W-1:0] paddr,
    output logic [31:0]         pwdata,
    output logic [3:0]          pstrb,
    input  logic [31:0]         prdata,
    input  logic                pready
);

    logic [31:0]      instruction;
    logic             read;
    logic             write;
    logic [2:0]       funct3;
    logic [4:0]       reg1;
    logic [4:0]       reg2;
    logic [4:0]       regd;
    logic             en_read_1;
    logic             en_read_2;
    logic             en_write;
    logic             jump;
    rv_pkg::wb_src_e  wb_src;
    rv_pkg::alu_op_e  alu_op;
    logic [`XLEN-1:0] immediate;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_result;
    logic             take_branch;
    logic             reg_we;
    logic [`XLEN-1:0] reg_wdata;

    mem_bus_if bus ();

    control_unit u_control (.instruction(instruction), .read(read), .write(write),
        .funct3(funct3), .reg1(reg1), .reg2(reg2), .regd(regd), .en_read_1(en_read_1),
        .en_read_2(en_read_2), .en_write(en_write), .wb_src(wb_src), .immediate(immediate),
        .alu_op(alu_op), .jump(jump));

    register_file u_regs (.clk(clk), .rst_n(rst_n),
        .raddr1(en_read_1 ? reg1 : 5'd0), .raddr2(en_read_2 ? reg2 : 5'd0), // Unused ports read x0
        .waddr(regd), .we(reg_we), .wdata(reg_wdata), .rdata1(rs1_data), .rdata2(rs2_data));

    alu u_alu (.op(alu_op), .a(rs1_data), .b(rs2_data), .pc(imem_addr), .imm(immediate),
        .result(alu_result), .take_branch(take_branch));

    core_sequencer u_seq (.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr),
        .imem_rdata(imem_rdata), .instruction(instruction), .read(read), .write(write),
        .en_write(en_write), .jump(jump), .funct3(funct3), .wb_src(wb_src), .alu_op(alu_op),
        .alu_result(alu_result), .take_branch(take_branch), .rs2_data(rs2_data),
        .reg_we(reg_we), .reg_wdata(reg_wdata), .bus(bus.seq));

    memory_handler u_mem (.clk(clk), .rst_n(rst_n), .bus(bus.hdl), .psel(psel),
        .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready));

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    // Decoder command codes with one per base instruction
    typedef enum logic [5:0] {
        alu_none = 6'd0,
        alu_add  = 6'd1, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        alu_addi = 6'd11, alu_slti, alu_sltiu, alu_xori, alu_ori,
        alu_andi, alu_slli, alu_srli, alu_srai,
        alu_lb   = 6'd20, alu_lh, alu_lw, alu_lbu, alu_lhu,
        alu_sb   = 6'd25, alu_sh, alu_sw,
        alu_beq  = 6'd28, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
        alu_lui  = 6'd34, alu_auipc, alu_jal, alu_jalr
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_none = 2'd0,
        wb_mem  = 2'd1,
        wb_link = 2'd2,
        wb_alu  = 2'd3
    } wb_src_e;

    // One instruction word seen through each format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [19:0] rest;
        } i;
        struct packed {
            logic [6:0]  imm_hi;
            logic [12:0] regs;   // rs2, rs1, funct3
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [12:0] regs;   // rs2, rs1, funct3
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [11:0] rest;
        } u;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [11:0] rest;
        } j;
    } instr_u;

endpackage

// File: sources.f
+incdir+logic
logic/rv_pkg.sv
logic/mem_bus_if.sv
logic/control_unit.sv
logic/register_file.sv
logic/alu.sv
logic/memory_handler.sv
logic/core_sequencer.sv
logic/rv_core_top.sv
testbench/core_tb.sv

// File: testbench/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;

    logic [31:0] rom [256];
    logic [31:0] dmem [1024];       // APB slave memory of 4 KB
    logic [31:0] model_mem [1024];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [31:0] acc_pc;            // PC of the model's last instruction
    logic [31:0] acc_addr;          // Word address of the model's last access
    logic [31:0] acc_data;
    logic [3:0]  acc_strb;
    logic [1:0]  wait_table [256];  // Wait cycles per APB transfer

    rv_core_top UUT (.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .pstrb(pstrb), .prdata(prdata), .pready(pready));

    assign imem_rdata = rom[imem_addr[9:2]];

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    // Executes one instruction on the model state and returns 0 none, 1 load or 2 store
    function automatic int step_model();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] lane;
        logic [31:0] next_pc;
        logic        take;
        logic        wr_en;
        int          kind;
        ins     = rom[model_pc[9:2]];
        a       = model_regs[ins[19:15]];
        b       = model_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        next_pc = model_pc + 4;
        res     = '0;
        addr    = '0;
        take    = 1'b0;
        wr_en   = 1'b0;
        kind    = 0;
        case (ins[6:0])
            7'h33, 7'h13: begin
                wr_en = 1'b1;
                if (!ins[5]) b = imm_i;  // I-type uses the immediate
                case (ins[14:12])
                    3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'd1: res = a << b[4:0];
                    3'd2: res = {31'b0, $signed(a) < $signed(b)};
                    3'd3: res = {31'b0, a < b};
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (ins[30]) res = $signed(a) >>> b[4:0];
                        else res = a >> b[4:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            7'h03: begin
                wr_en = 1'b1;
                kind  = 1;
                addr  = a + imm_i;
                lane  = model_mem[addr[11:2]] >> {addr[1:0], 3'b000};
                case (ins[14:12])
                    3'd0: res = {{24{lane[7]}}, lane[7:0]};
                    3'd1: res = {{16{lane[15]}}, lane[15:0]};
                    3'd4: res = {24'b0, lane[7:0]};
                    3'd5: res = {16'b0, lane[15:0]};
                    default: res = lane;
                endcase
            end
            7'h23: begin
                kind     = 2;
                addr     = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                acc_strb = (ins[13:12] == 2'd0) ? 4'b0001 << addr[1:0] :
                           (ins[13:12] == 2'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
                acc_data = (ins[13:12] == 2'd0) ? {4{b[7:0]}} :
                           (ins[13:12] == 2'd1) ? {2{b[15:0]}} : b;
                for (int k = 0; k < 4; k++) begin
                    if (acc_strb[k]) model_mem[addr[11:2]][8*k +: 8] = acc_data[8*k +: 8];
                end
            end
            7'h63: begin
                case (ins[14:12])
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = $signed(a) < $signed(b);
                    3'd5: take = $signed(a) >= $signed(b);
                    3'd6: take = a < b;
                    3'd7: take = a >= b;
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next_pc = model_pc +
                              {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'h37: begin
                wr_en = 1'b1;
                res   = {ins[31:12], 12'b0};
            end
            7'h17: begin
                wr_en = 1'b1;
                res   = model_pc + {ins[31:12], 12'b0};
            end
            7'h6f: begin
                wr_en   = 1'b1;
                res     = model_pc + 4;
                next_pc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                wr_en   = 1'b1;
                res     = model_pc + 4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: ;  // Unknown encoding only advances the PC
        endcase
        if (wr_en && ins[11:7] != 5'd0) model_regs[ins[11:7]] = res;
        acc_addr = {addr[31:2], 2'b00};
        acc_pc   = model_pc;
        model_pc = next_pc;
        return kind;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // APB slave with 0 to 3 wait cycles per transfer
    initial begin : apb_slave
        int         waits_left;
        logic [7:0] slot;
        waits_left = 0;
        slot       = '0;
        forever begin
            @(posedge clk);
            #1;
            if (psel && !penable) begin
                waits_left = wait_table[slot];
                slot       = slot + 1;
                pready     = 1'b0;
            end else if (psel && penable && waits_left > 0) begin
                waits_left = waits_left - 1;
            end else if (psel && penable) begin
                pready = 1'b1;
                if (pwrite) begin
                    for (int k = 0; k < 4; k++) begin
                        if (pstrb[k]) dmem[paddr[11:2]][8*k +: 8] = pwdata[8*k +: 8];
                    end
                end else begin
                    prdata = dmem[paddr[11:2]];
                end
            end else begin
                pready = 1'b0;
            end
        end
    end

    initial begin : apb_rules
        logic [31:0] held_addr;
        logic [31:0] held_data;
        logic [3:0]  held_strb;
        logic        held_write;
        logic        stalled;
        held_addr  = '0;
        held_data  = '0;
        held_strb  = '0;
        held_write = 1'b0;
        stalled    = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst_n) check_value("psel during reset", psel, 0);
            if (stalled) check_value("psel and penable in wait cycle", {psel, penable}, 2'b11);
            if (psel && !penable) begin  // Setup phase
                held_addr  = paddr;
                held_data  = pwdata;
                held_strb  = pstrb;
                held_write = pwrite;
            end
            if (penable) begin
                check_value("psel with penable", psel, 1);
                check_value("paddr in access phase", paddr, held_addr);
                check_value("pwrite in access phase", pwrite, held_write);
                check_value("pwdata in access phase", pwdata, held_data);
                check_value("pstrb in access phase", pstrb, held_strb);
            end
            stalled = psel && penable && !pready;
        end
    end

    initial begin : compare_flow
        int   cycles;
        int   steps;
        int   transfers;
        int   kind;
        logic finished;
        rst_n    = 1'b0;
        pready   = 1'b0;
        prdata   = '0;
        model_pc = 32'h0;
        void'($urandom(32'hc265));
        for (int i = 0; i < 1024; i++) begin
            dmem[i]      = $urandom;
            model_mem[i] = dmem[i];
        end
        for (int i = 0; i < 256; i++) wait_table[i] = 2'($urandom % 4);
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        $readmemh("testbench/program.hex", rom);
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        transfers = 0;
        finished  = 1'b0;
        while (!finished) begin
            cycles = 0;
            @(negedge clk);
            while (!(psel && penable && pready)) begin
                cycles++;
                if (cycles > 2000) begin
                    $display("Core stopped making progress, no APB transfer in 2000 cycles");
                    $display("Testbench failed");
                    $fatal(1, "Timeout");
                end
                @(negedge clk);
            end
            kind  = 0;
            steps = 0;
            while (kind == 0) begin
                kind = step_model();
                steps++;
                if (steps > 2000) begin
                    $display("Reference model ran 2000 instructions without a load or store");
                    $display("Testbench failed");
                    $fatal(1, "Model runaway");
                end
            end
            check_value("imem_addr during transfer", imem_addr, acc_pc);
            check_value("pwrite", pwrite, kind == 2);
            check_value("paddr", paddr, acc_addr);
            if (kind == 2) begin
                check_value("pstrb", pstrb, acc_strb);
                check_value("pwdata under pstrb", pwdata & lane_mask(pstrb),
                            acc_data & lane_mask(acc_strb));
                if (acc_addr == 32'h0000_0ffc) finished = 1'b1;  // End of program
            end
            transfers++;
            if (transfers > 1000) begin
                $display("Program did not reach its final store within 1000 transfers");
                $display("Testbench failed");
                $fatal(1, "Too many transfers");
            end
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: testbench/program.hex
// Ten instruction words per line, line n starts at byte address 0x28*n
// ALU ops, lane stores, loads, AUIPC, six branch pairs, JAL/JALR, final store to 0xFFC
10000513 876540B7 32108093 FFB00113 00700393 00208333 00652023 40208333 00652023 0020A333
00652023 00113333 00652023 00709333 00652023 0070D333 00652023 4070D333 00652023 0020C333
00652023 0020E333 00652023 0070F333 00652023 FFF0A313 00652023 00513313 00652023 7F00C313
00652023 10016313 00652023 F000F313 00652023 00D09313 00652023 0110D313 00652023 40D0D313
00652023 00150023 001500A3 00150123 001501A3 00251023 00251123 10150303 00652023 10651303
00652023 10852303 00652023 10F54303 00652023 10C55303 00652023 12345317 00652023 00000000
00208463 00130313 00738463 01030313 00652023 00739463 00130313 00209463 01030313 00652023
0013C463 00130313 0070C463 01030313 00652023 0070D463 00130313 0013D463 01030313 00652023
00116463 00130313 0020E463 01030313 00652023 0013F463 00130313 00117463 01030313 00652023
00C002EF 01030313 01030313 00552023 00000417 011404E7 01030313 01030313 00952023 00652023
00001637 FE662E23
